/* Makefile */
TOP = axil_sram_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/axil_sram_bridge.sv */
`timescale 1ns/1ps
`include "axil_sram_defines.svh"

module axil_sram_bridge (
    input  logic                       clk,
    input  logic                       rst,

    // Write address channel
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`AXIL_ADDR_W-1:0]    awaddr,

    // Write data channel
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [`AXIL_DATA_W-1:0]    wdata,
    input  logic [`AXIL_STRB_W-1:0]    wstrb,

    // Write response channel
    output logic                       bvalid,
    input  logic                       bready,
    output axil_sram_pkg::axil_resp_e  bresp,

    // Read address channel
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [`AXIL_ADDR_W-1:0]    araddr,

    // Read data channel
    output logic                       rvalid,
    input  logic                       rready,
    output logic [`AXIL_DATA_W-1:0]    rdata,
    output axil_sram_pkg::axil_resp_e  rresp,

    // SRAM request, one-cycle strobe
    output logic                       req_valid,
    output axil_sram_pkg::sram_req_t   req,

    // SRAM response, one-cycle strobe
    input  logic                       rsp_valid,
    input  axil_sram_pkg::sram_rsp_t   rsp
);
    import axil_sram_pkg::*;

    typedef enum logic [1:0] {
        IDLE,        // Ready for a new transaction
        WAIT_SRAM,   // Decode, issue, then wait for the array
        WRITE_RESP,  // Holding B until bready
        READ_RESP    // Holding R until rready
    } state_e;

    localparam logic [`AXIL_ADDR_W-1:0] BASE = `SRAM_BASE;

    state_e                   state;
    logic                     rdy;        // Registered ready, high only in IDLE
    logic                     cap;        // Request captured, not yet decoded
    logic                     hit_q;      // Captured address falls in the window
    logic                     write_hs;   // AW and W taken together
    logic                     read_hs;    // AR taken
    logic [`AXIL_ADDR_W-1:0]  sel_addr;   // Address of the winning request
    logic                     sel_hit;

    // AW and W are always accepted as a pair
    assign awready = rdy;
    assign wready  = rdy;

    // A pending write blocks AR so that both cannot transfer at one edge
    assign arready = rdy & ~(awvalid & wvalid);

    assign write_hs = rdy & awvalid & wvalid;
    assign read_hs  = arready & arvalid;

    // Write has priority
    assign sel_addr = write_hs ? awaddr : araddr;

    // Upper address bits must match the base of the window
    assign sel_hit = (sel_addr[`AXIL_ADDR_W-1:`SRAM_OFFSET_W]
                      == BASE[`AXIL_ADDR_W-1:`SRAM_OFFSET_W]);

    // Control path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            rdy       <= 1'b0;
            cap       <= 1'b0;
            req_valid <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= OKAY;
            rvalid    <= 1'b0;
            rresp     <= OKAY;
        end else begin
            req_valid <= 1'b0;  // Strobe by default
            case (state)
                IDLE: begin
                    if (write_hs || read_hs) begin
                        rdy   <= 1'b0;  // Stop accepting until the response is taken
                        cap   <= 1'b1;
                        state <= WAIT_SRAM;
                    end else begin
                        rdy <= 1'b1;    // Also the first ready after reset
                    end
                end

                WAIT_SRAM: begin
                    if (cap) begin
                        // First cycle after the handshake
                        cap <= 1'b0;
                        if (hit_q) begin
                            req_valid <= 1'b1;  // Off to the pipeline
                        end else if (req.write) begin
                            bvalid <= 1'b1;
                            bresp  <= DECERR;
                            state  <= WRITE_RESP;
                        end else begin
                            rvalid <= 1'b1;
                            rresp  <= DECERR;
                            state  <= READ_RESP;
                        end
                    end else if (rsp_valid) begin
                        // Array answered
                        if (req.write) begin
                            bvalid <= 1'b1;
                            bresp  <= OKAY;
                            state  <= WRITE_RESP;
                        end else begin
                            rvalid <= 1'b1;
                            rresp  <= OKAY;
                            state  <= READ_RESP;
                        end
                    end
                end

                WRITE_RESP: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= IDLE;   // Ready rises on the next edge
                    end
                end

                READ_RESP: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        // Handshakes only happen in IDLE
        if (write_hs || read_hs) begin
            req.write <= write_hs;
            req.index <= sel_addr[`SRAM_OFFSET_W-1:2];    // Word index
            req.wdata <= wdata;
            req.wmask <= write_hs ? wstrb : '0;           // No lanes on reads
            hit_q     <= sel_hit;
        end

        // Read data only changes on the way into READ_RESP
        if (state == WAIT_SRAM && !req.write) begin
            if (cap) begin
                rdata <= '0;             // Stays zero for DECERR
            end else if (rsp_valid) begin
                rdata <= rsp.rdata;
            end
        end
    end

endmodule

/* design/axil_sram_pkg.sv */
package axil_sram_pkg;

`include "axil_sram_defines.svh"

    // AXI response codes
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2,   // Not produced by this slave
        DECERR = 2'd3    // Address outside the SRAM window
    } axil_resp_e;

    // One SRAM access as issued by the bridge
    typedef struct packed {
        logic                     write;   // 1 = write, 0 = read
        logic [`SRAM_INDEX_W-1:0] index;   // Word address
        logic [`AXIL_DATA_W-1:0]  wdata;
        logic [`AXIL_STRB_W-1:0]  wmask;   // Byte enables for writes
    } sram_req_t;

    // Response from the array
    // Writes return one too, rdata is then don't-care
    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] rdata;
    } sram_rsp_t;

endpackage

/* design/axil_sram_top.sv */
`timescale 1ns/1ps
`include "axil_sram_defines.svh"

module axil_sram_top (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`AXIL_ADDR_W-1:0]    awaddr,

    input  logic                       wvalid,
    output logic                       wready,
    input  logic [`AXIL_DATA_W-1:0]    wdata,
    input  logic [`AXIL_STRB_W-1:0]    wstrb,

    output logic                       bvalid,
    input  logic                       bready,
    output axil_sram_pkg::axil_resp_e  bresp,

    input  logic                       arvalid,
    output logic                       arready,
    input  logic [`AXIL_ADDR_W-1:0]    araddr,

    output logic                       rvalid,
    input  logic                       rready,
    output logic [`AXIL_DATA_W-1:0]    rdata,
    output axil_sram_pkg::axil_resp_e  rresp
);
    import axil_sram_pkg::*;

    logic      req_valid;   // Bridge to pipeline
    sram_req_t req;
    logic      mem_en;      // Pipeline to array
    sram_req_t mem_req;
    logic      rsp_valid;   // Array back to bridge
    sram_rsp_t rsp;

    // AXI slave side
    axil_sram_bridge i_axil_sram_bridge (
        .clk       (clk),
        .rst       (rst),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // Fixed access latency
    sram_access_pipe #(
        .LATENCY (`SRAM_LATENCY)
    ) i_sram_access_pipe (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .mem_en    (mem_en),
        .mem_req   (mem_req)
    );

    // Storage
    sram_array i_sram_array (
        .clk       (clk),
        .rst       (rst),
        .mem_en    (mem_en),
        .mem_req   (mem_req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

/* design/sram_access_pipe.sv */
`timescale 1ns/1ps
`include "axil_sram_defines.svh"

module sram_access_pipe #(
    parameter int LATENCY = `SRAM_LATENCY   // Stages between bridge and array
) (
    input  logic                      clk,
    input  logic                      rst,

    // From the bridge
    input  logic                      req_valid,
    input  axil_sram_pkg::sram_req_t  req,

    // To the array
    output logic                      mem_en,
    output axil_sram_pkg::sram_req_t  mem_req
);
    import axil_sram_pkg::*;

    // Models a slow macro
    // Each stage carries its own request so several can be in flight
    logic [LATENCY-1:0] stage_vld;
    sram_req_t          stage_req [LATENCY];

    // Valid chain
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_vld <= '0;
        end else begin
            stage_vld[0] <= req_valid;
            for (int i = 1; i < LATENCY; i++) begin
                stage_vld[i] <= stage_vld[i-1];
            end
        end
    end

    // Request chain
    // Registers only load when a valid request moves in
    always_ff @(posedge clk) begin
        if (req_valid) begin
            stage_req[0] <= req;
        end
        for (int i = 1; i < LATENCY; i++) begin
            if (stage_vld[i-1]) begin
                stage_req[i] <= stage_req[i-1];
            end
        end
    end

    // Last stage feeds the array
    assign mem_en  = stage_vld[LATENCY-1];
    assign mem_req = stage_req[LATENCY-1];

endmodule

/* design/sram_array.sv */
`timescale 1ns/1ps
`include "axil_sram_defines.svh"

module sram_array (
    input  logic                      clk,
    input  logic                      rst,

    // Access port
    input  logic                      mem_en,
    input  axil_sram_pkg::sram_req_t  mem_req,

    // Registered response
    output logic                      rsp_valid,
    output axil_sram_pkg::sram_rsp_t  rsp
);
    import axil_sram_pkg::*;

    logic [`AXIL_DATA_W-1:0] mem [`SRAM_DEPTH];   // Contents not reset

    // One response per access
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= mem_en;
        end
    end

    // Storage and read register
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_req.write) begin
                for (int b = 0; b < `AXIL_STRB_W; b++) begin
                    if (mem_req.wmask[b]) begin
                        mem[mem_req.index][8*b +: 8] <= mem_req.wdata[8*b +: 8];  // Byte lane
                    end
                end
            end else begin
                rsp.rdata <= mem[mem_req.index];
            end
        end
    end

endmodule

/* include/axil_sram_defines.svh */
`ifndef AXIL_SRAM_DEFINES_SVH
`define AXIL_SRAM_DEFINES_SVH

// AXI4-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)  // One strobe bit per byte lane

// SRAM geometry
`define SRAM_INDEX_W 10                       // Word index bits
`define SRAM_DEPTH (1 << `SRAM_INDEX_W)       // 1024 words
`define SRAM_OFFSET_W (`SRAM_INDEX_W + 2)     // Byte offset inside the 4 KB window

// Stages in the access pipeline
`define SRAM_LATENCY 2

// Window base address
// Only the bits above SRAM_OFFSET_W take part in the decode
`define SRAM_BASE 32'h8000_0000

`endif

/* verification/axil_sram_properties.sv */
`timescale 1ns/1ps
`include "axil_sram_defines.svh"

module axil_sram_properties (
    input logic                       clk,
    input logic                       rst,
    input logic                       awready,
    input logic                       wready,
    input logic                       arready,
    input logic                       bvalid,
    input logic                       bready,
    input axil_sram_pkg::axil_resp_e  bresp,
    input logic                       rvalid,
    input logic                       rready,
    input logic [`AXIL_DATA_W-1:0]    rdata,
    input axil_sram_pkg::axil_resp_e  rresp
);

    // B held with its code until bready
    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
        else $error("bvalid dropped or bresp changed before bready");

    // R held with code and data until rready
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> (rvalid && $stable(rresp) && $stable(rdata)))
        else $error("rvalid dropped or R payload changed before rready");

    // One transaction at a time
    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        !(bvalid && rvalid))
        else $error("bvalid and rvalid high together");

    // No new request taken while a response waits
    a_no_accept: assert property (@(posedge clk) disable iff (rst)
        (bvalid || rvalid) |-> !(awready || wready || arready))
        else $error("ready output high while a response is pending");

endmodule

bind axil_sram_top axil_sram_properties i_axil_sram_properties (
    .clk     (clk),
    .rst     (rst),
    .awready (awready),
    .wready  (wready),
    .arready (arready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
);

/* verification/axil_sram_tb.sv */
`timescale 1ns/1ps
`include "axil_sram_defines.svh"

module axil_sram_tb;
    import axil_sram_pkg::*;

    localparam int PERIOD      = 100;
    localparam int N_RAND      = 200;
    localparam int N_DEC       = 40;
    localparam int N_BP        = 40;
    localparam int N_COL       = 20;
    localparam int N_LAT       = 8;
    localparam int BP_MAX      = 6;                   // Longest bready/rready stall
    localparam int TXN_CYCLES  = `SRAM_LATENCY + 8;   // Worst case without stall
    localparam int N_TXN       = `SRAM_DEPTH + 2*N_RAND + 3*N_DEC + 2*N_BP + 2*N_COL + 4*N_LAT;
    localparam int WATCHDOG_NS = (N_TXN * (TXN_CYCLES + BP_MAX) + 20) * PERIOD;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      awvalid, awready, wvalid, wready, bvalid, bready;
    logic                      arvalid, arready, rvalid, rready;
    logic [`AXIL_ADDR_W-1:0]   awaddr, araddr;
    logic [`AXIL_DATA_W-1:0]   wdata, rdata;
    logic [`AXIL_STRB_W-1:0]   wstrb;
    axil_resp_e                bresp, rresp;

    int unsigned               cycle = 0;             // Rising edges so far
    int                        errors = 0;
    int                        n_ok = 0;
    int                        n_bad = 0;
    int                        n_txn = 0;
    logic [`AXIL_DATA_W-1:0]   model_mem [`SRAM_DEPTH];   // Reference memory
    logic [`AXIL_ADDR_W-1:0]   wr_addrs [$];          // Addresses written in the random test

    axil_sram_top i_axil_sram_top (.*);

    always #(PERIOD/2) clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog: run did not complete within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    // Drive point is 10 ns after the edge
    task automatic step_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("** Error @ %0t: %s", $time, msg);
    endtask

    function automatic bit in_window(input logic [`AXIL_ADDR_W-1:0] addr);
        logic [`AXIL_ADDR_W-1:0] base;
        base = `SRAM_BASE;
        return addr[`AXIL_ADDR_W-1:`SRAM_OFFSET_W] == base[`AXIL_ADDR_W-1:`SRAM_OFFSET_W];
    endfunction

    function automatic logic [`AXIL_ADDR_W-1:0] random_inside();
        return `SRAM_BASE | {{(`AXIL_ADDR_W-`SRAM_OFFSET_W){1'b0}}, `SRAM_INDEX_W'($urandom), 2'b00};
    endfunction

    function automatic logic [`AXIL_ADDR_W-1:0] random_outside();
        logic [`AXIL_ADDR_W-1:0] addr;
        addr = $urandom;
        while (in_window(addr)) addr = $urandom;   // Rarely loops
        return addr;
    endfunction

    task automatic model_write(input logic [`AXIL_ADDR_W-1:0] addr,
                               input logic [`AXIL_DATA_W-1:0] data,
                               input logic [`AXIL_STRB_W-1:0] strb);
        for (int b = 0; b < `AXIL_STRB_W; b++) begin
            if (strb[b]) model_mem[addr[`SRAM_OFFSET_W-1:2]][8*b +: 8] = data[8*b +: 8];
        end
    endtask

    // One AXI write, B stalled for delay cycles once it shows up
    task automatic write_txn(input logic [`AXIL_ADDR_W-1:0] addr,
                             input logic [`AXIL_DATA_W-1:0] data,
                             input logic [`AXIL_STRB_W-1:0] strb, input int delay,
                             input bit early, output axil_resp_e resp, output int lat);
        int unsigned hs;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        bready  = early;
        #1;
        while (!(awready && wready)) begin
            step_cycle();
            #1;
        end
        if (arready) note_error("arready high while a write is offered");
        step_cycle();                           // AW and W taken here
        hs      = cycle;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        awaddr  = $urandom;                     // Scramble the idle payload
        wdata   = $urandom;
        while (!bvalid) step_cycle();
        lat  = int'(cycle - hs);
        resp = bresp;
        if (rvalid) note_error("rvalid high while a write response is pending");
        repeat (delay) begin
            step_cycle();
            if (!bvalid || bresp !== resp) note_error("B response changed before bready");
            if (awready || wready || arready) note_error("ready raised during B stall");
        end
        bready = 1'b1;
        step_cycle();
        bready = 1'b0;
        if (bvalid) note_error("bvalid still high after the B handshake");
        n_txn++;
    endtask

    task automatic read_txn(input logic [`AXIL_ADDR_W-1:0] addr, input int delay,
                            input bit early, output axil_resp_e resp,
                            output logic [`AXIL_DATA_W-1:0] data, output int lat);
        int unsigned hs;
        arvalid = 1'b1;
        araddr  = addr;
        rready  = early;
        #1;
        while (!arready) begin
            step_cycle();
            #1;
        end
        step_cycle();                           // AR taken here
        hs      = cycle;
        arvalid = 1'b0;
        araddr  = $urandom;
        while (!rvalid) step_cycle();
        lat  = int'(cycle - hs);
        resp = rresp;
        data = rdata;
        if (bvalid) note_error("bvalid high while a read response is pending");
        repeat (delay) begin
            step_cycle();
            if (!rvalid || rresp !== resp || rdata !== data) begin
                note_error("R response changed before rready");
            end
            if (awready || wready || arready) note_error("ready raised during R stall");
        end
        rready = 1'b1;
        step_cycle();
        rready = 1'b0;
        if (rvalid) note_error("rvalid still high after the R handshake");
        n_txn++;
    endtask

    task automatic checked_write(input logic [`AXIL_ADDR_W-1:0] addr,
                                 input logic [`AXIL_DATA_W-1:0] data,
                                 input logic [`AXIL_STRB_W-1:0] strb, input int delay,
                                 input bit early, output int lat);
        axil_resp_e resp;
        axil_resp_e exp;
        exp = in_window(addr) ? OKAY : DECERR;
        write_txn(addr, data, strb, delay, early, resp, lat);
        if (resp !== exp) begin
            note_error($sformatf("write %h bresp %s, expected %s", addr, resp.name(), exp.name()));
        end
        if (exp == OKAY) model_write(addr, data, strb);   // DECERR leaves memory alone
    endtask

    task automatic checked_read(input logic [`AXIL_ADDR_W-1:0] addr, input int delay,
                                input bit early, output int lat);
        axil_resp_e              resp;
        axil_resp_e              exp;
        logic [`AXIL_DATA_W-1:0] data;
        logic [`AXIL_DATA_W-1:0] exp_data;
        exp      = in_window(addr) ? OKAY : DECERR;
        exp_data = (exp == OKAY) ? model_mem[addr[`SRAM_OFFSET_W-1:2]] : '0;
        read_txn(addr, delay, early, resp, data, lat);
        if (resp !== exp || data !== exp_data) begin
            note_error($sformatf("read %h got %h %s, expected %h %s", addr, data,
                                 resp.name(), exp_data, exp.name()));
        end
    endtask

    task automatic check_latency(input int lat, input int exp, input string what);
        if (lat != exp) note_error($sformatf("%s latency %0d, expected %0d", what, lat, exp));
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            n_ok++;
            $display("[%0t] test %-12s ok", $time, name);
        end else begin
            n_bad++;
            $display("[%0t] test %-12s FAIL, %0d errors", $time, name, errors - errs_before);
        end
    endtask

    initial begin : main
        int                      mark;
        int                      lat;
        logic [`AXIL_ADDR_W-1:0] addr;
        void'($urandom(32'h2e99_ccef));
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;

        mark = errors;
        repeat (8) begin
            step_cycle();
            if (awready || wready || arready || bvalid || rvalid || i_axil_sram_top.req_valid
                || i_axil_sram_top.mem_en || i_axil_sram_top.rsp_valid) begin
                note_error("valid or ready output high during reset");
            end
        end
        rst = 1'b0;
        #1;
        if (awready || wready || arready || bvalid || rvalid) note_error("output high at release");
        step_cycle();
        if (bvalid || rvalid) note_error("response valid after the first edge out of reset");
        if (!(awready && wready && arready)) note_error("ready did not rise after reset");
        finish_test("reset", mark);

        // Every word gets a value that depends on its full index
        mark = errors;
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            addr = `SRAM_BASE | (i << 2);
            checked_write(addr, {6'h2b, 10'(i), 6'h15, ~10'(i)}, '1, 0, 1'b0, lat);
        end
        finish_test("preload", mark);

        mark = errors;
        for (int i = 0; i < N_RAND; i++) begin
            addr = random_inside();
            wr_addrs.push_back(addr);
            checked_write(addr, $urandom, `AXIL_STRB_W'($urandom), 0, 1'b0, lat);
        end
        for (int i = 0; i < N_RAND; i++) begin
            checked_read(wr_addrs[$urandom % wr_addrs.size()], 0, 1'b0, lat);
        end
        finish_test("random", mark);

        mark = errors;
        for (int i = 0; i < N_DEC; i++) begin
            addr = random_outside();
            checked_write(addr, $urandom, `AXIL_STRB_W'($urandom), 0, 1'b0, lat);
            checked_read(addr, 0, 1'b0, lat);
            checked_read(`SRAM_BASE | (addr & ((1 << `SRAM_OFFSET_W) - 4)), 0, 1'b0, lat);
        end
        finish_test("decode", mark);

        mark = errors;
        for (int i = 0; i < N_BP; i++) begin
            checked_write(random_inside(), $urandom, `AXIL_STRB_W'($urandom),
                          $urandom % (BP_MAX + 1), 1'b0, lat);
            checked_read(random_inside(), $urandom % (BP_MAX + 1), 1'b0, lat);
        end
        finish_test("backpressure", mark);

        // AR held through the whole write
        mark = errors;
        for (int i = 0; i < N_COL; i++) begin
            addr    = random_inside();
            arvalid = 1'b1;
            araddr  = addr;
            checked_write(addr, $urandom, `AXIL_STRB_W'($urandom), 0, 1'b0, lat);
            checked_read(addr, 0, 1'b0, lat);
        end
        finish_test("collision", mark);

        mark = errors;
        for (int i = 0; i < N_LAT; i++) begin
            checked_write(random_inside(), $urandom, `AXIL_STRB_W'($urandom), 0, 1'b1, lat);
            check_latency(lat, `SRAM_LATENCY + 3, "in-range write");
            checked_read(random_inside(), 0, 1'b1, lat);
            check_latency(lat, `SRAM_LATENCY + 3, "in-range read");
            checked_write(random_outside(), $urandom, `AXIL_STRB_W'($urandom), 0, 1'b1, lat);
            check_latency(lat, 1, "DECERR write");
            checked_read(random_outside(), 0, 1'b1, lat);
            check_latency(lat, 1, "DECERR read");
        end
        finish_test("latency", mark);

        $display("Summary: %0d tests ok, %0d failing, %0d transactions, %0d errors",
                 n_ok, n_bad, n_txn, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
design/axil_sram_pkg.sv
design/sram_array.sv
design/sram_access_pipe.sv
design/axil_sram_bridge.sv
design/axil_sram_top.sv
verification/axil_sram_properties.sv
verification/axil_sram_tb.sv
